/* verilog/cache_pkg.sv */
package cache_pkg;

  // address and data geometry
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;
  localparam int MASK_W = 4;
  localparam int BYTE_W = WORD_W / MASK_W;

  // way organisation
  localparam int NUM_WAYS = 2;
  localparam int LG_LINES = 6;       // lines per way
  localparam int LG_BLOCK = 2;       // words per line
  localparam int INDEX_W = LG_LINES + LG_BLOCK;
  localparam int INDEX_LSB = 2;      // word index starts above the byte offset

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [MASK_W-1:0] mask_t;
  typedef logic [INDEX_W-1:0] index_t;

endpackage

/* verilog/wbuf_pkg.sv */
package wbuf_pkg;

  import cache_pkg::*;

  localparam int WBUF_ELS = 2;

  // occupancy 0..WBUF_ELS
  typedef logic [$clog2(WBUF_ELS+1)-1:0] count_t;

  // one committed store waiting for the data memory
  typedef struct packed {
    addr_t addr;
    word_t data;
    mask_t mask;
    logic  set;   // target way
  } wbuf_entry_t;

  // bytes forwarded to a load, valid per byte lane
  typedef struct packed {
    word_t data;
    mask_t valid;
  } bypass_t;

endpackage

/* verilog/write_buffer_queue.sv */
`timescale 1ns/100ps

module write_buffer_queue
  import wbuf_pkg::*;
(
  input  logic        clk_i,
  input  wbuf_entry_t data_i,
  input  logic        el0_en_i,
  input  logic        el1_en_i,
  input  logic        mux0_sel_i,
  input  logic        mux1_sel_i,
  output wbuf_entry_t el0_o,
  output wbuf_entry_t el1_o,
  output wbuf_entry_t final_o
);

  wbuf_entry_t el0_r;
  wbuf_entry_t el1_r;
  wbuf_entry_t el1_n;

  // slot 1 is the older entry, it takes slot 0 when that one is occupied
  assign el1_n = mux0_sel_i ? el0_r : data_i;

  always_ff @(posedge clk_i) begin
    if (el0_en_i) begin
      el0_r <= data_i;
    end
    if (el1_en_i) begin
      el1_r <= el1_n;
    end
  end

  // empty buffer passes the incoming store straight through
  assign final_o = mux1_sel_i ? el1_r : data_i;

  assign el0_o = el0_r;   // snoop taps for bypass
  assign el1_o = el1_r;

endmodule

/* verilog/write_buffer.sv */
`timescale 1ns/100ps

module write_buffer
  import cache_pkg::*;
  import wbuf_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  wbuf_entry_t store_i,
  input  logic        store_v_i,
  input  logic        data_mem_free_i,
  input  addr_t       load_addr_i,
  input  logic        load_v_i,
  output wbuf_entry_t mem_wr_o,
  output logic        mem_we_o,
  output bypass_t     bypass_o,
  output logic        full_o,
  output logic        empty_o
);

  count_t      num_els_r;
  logic        el0_valid;
  logic        el1_valid;
  logic        el0_en;
  logic        el1_en;
  logic        drain;
  wbuf_entry_t el0;
  wbuf_entry_t el1;
  logic        hit0;
  logic        hit1;
  logic        hit2;
  mask_t       sel0;
  mask_t       sel1;
  mask_t       sel2;
  bypass_t     bypass_n;

  // el1 holds the oldest entry, el0 only fills when two are buffered
  assign el0_valid = (num_els_r == count_t'(WBUF_ELS));
  assign el1_valid = (num_els_r != '0);

  assign full_o  = el0_valid;
  assign empty_o = ~el1_valid;

  assign drain    = (el1_valid | store_v_i) & data_mem_free_i;
  assign mem_we_o = drain;

  // a slot moves whenever the head leaves, else only fills when free
  assign el0_en = drain | ~el0_valid;
  assign el1_en = drain | ~el1_valid;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      num_els_r <= '0;
    end else begin
      num_els_r <= num_els_r + count_t'(store_v_i) - count_t'(drain);
    end
  end

  write_buffer_queue u_queue (
    .clk_i      (clk_i),
    .data_i     (store_i),
    .el0_en_i   (el0_en),
    .el1_en_i   (el1_en),
    .mux0_sel_i (el0_valid),
    .mux1_sel_i (el1_valid),
    .el0_o      (el0),
    .el1_o      (el1),
    .final_o    (mem_wr_o)
  );

  // word address compare, byte offset ignored
  assign hit0 = el0_valid & (load_addr_i[ADDR_W-1:INDEX_LSB] == el0.addr[ADDR_W-1:INDEX_LSB]);
  assign hit1 = el1_valid & (load_addr_i[ADDR_W-1:INDEX_LSB] == el1.addr[ADDR_W-1:INDEX_LSB]);
  assign hit2 = store_v_i & (load_addr_i[ADDR_W-1:INDEX_LSB] == store_i.addr[ADDR_W-1:INDEX_LSB]);

  assign sel0 = {MASK_W{hit0}} & el0.mask;
  assign sel1 = {MASK_W{hit1}} & el1.mask;
  assign sel2 = {MASK_W{hit2}} & store_i.mask;

  // youngest wins: incoming store, then el0, then el1
  always_comb begin
    for (int b = 0; b < MASK_W; b++) begin
      if (sel2[b]) begin
        bypass_n.data[b*BYTE_W +: BYTE_W] = store_i.data[b*BYTE_W +: BYTE_W];
      end else if (sel0[b]) begin
        bypass_n.data[b*BYTE_W +: BYTE_W] = el0.data[b*BYTE_W +: BYTE_W];
      end else begin
        bypass_n.data[b*BYTE_W +: BYTE_W] = el1.data[b*BYTE_W +: BYTE_W];
      end
    end
    bypass_n.valid = {MASK_W{load_v_i}} & (sel0 | sel1 | sel2);
  end

  always_ff @(posedge clk_i) begin
    bypass_o <= bypass_n;   // lines up with the registered memory read
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (store_v_i && full_o) |-> mem_we_o)
    else $error("store accepted while write buffer full and not draining");

  a_count_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    num_els_r <= count_t'(WBUF_ELS))
    else $error("write buffer occupancy out of range");

endmodule

/* verilog/data_mem.sv */
`timescale 1ns/100ps

module data_mem
  import cache_pkg::*;
  import wbuf_pkg::*;
(
  input  logic        clk_i,
  input  wbuf_entry_t wr_i,
  input  logic        we_i,
  input  addr_t       rd_addr_i,
  input  logic        rd_set_i,
  input  logic        re_i,
  output word_t       rd_data_o
);

  // one word array per way
  word_t  mem [NUM_WAYS][2**INDEX_W];
  index_t wr_idx;
  index_t rd_idx;

  assign wr_idx = wr_i.addr[INDEX_LSB +: INDEX_W];
  assign rd_idx = rd_addr_i[INDEX_LSB +: INDEX_W];

  // byte masked write, only enabled lanes change
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < MASK_W; b++) begin
        if (wr_i.mask[b]) begin
          mem[wr_i.set][wr_idx][b*BYTE_W +: BYTE_W] <= wr_i.data[b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rd_data_o <= mem[rd_set_i][rd_idx];   // data valid the cycle after issue
    end
  end

  // the top gives loads the port, drains must wait
  a_single_port: assert property (@(posedge clk_i) !(we_i && re_i))
    else $error("data memory read and write in the same cycle");

endmodule

/* verilog/load_merge.sv */
`timescale 1ns/100ps

module load_merge
  import cache_pkg::*;
  import wbuf_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    load_v_i,
  input  word_t   mem_data_i,
  input  bypass_t bypass_i,
  output word_t   load_data_o,
  output logic    load_v_o
);

  logic load_v_r;

  // memory read data and bypass bytes are both one cycle behind the request
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      load_v_r <= 1'b0;
    end else begin
      load_v_r <= load_v_i;
    end
  end

  assign load_v_o = load_v_r;

  always_comb begin
    for (int b = 0; b < MASK_W; b++) begin
      load_data_o[b*BYTE_W +: BYTE_W] = bypass_i.valid[b] ? bypass_i.data[b*BYTE_W +: BYTE_W]
                                                          : mem_data_i[b*BYTE_W +: BYTE_W];
    end
  end

endmodule

/* verilog/dcache_store_path.sv */
`timescale 1ns/100ps

module dcache_store_path
  import cache_pkg::*;
  import wbuf_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  wbuf_entry_t store_i,
  input  logic        store_v_i,
  input  addr_t       load_addr_i,
  input  logic        load_set_i,
  input  logic        load_v_i,
  output word_t       load_data_o,
  output logic        load_v_o,
  output logic        wbuf_full_o,
  output logic        wbuf_empty_o
);

  logic        data_mem_free;
  wbuf_entry_t mem_wr;
  logic        mem_we;
  bypass_t     bypass;
  word_t       rd_data;

  assign data_mem_free = ~load_v_i;   // loads own the port

  write_buffer u_wbuf (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .store_i         (store_i),
    .store_v_i       (store_v_i),
    .data_mem_free_i (data_mem_free),
    .load_addr_i     (load_addr_i),
    .load_v_i        (load_v_i),
    .mem_wr_o        (mem_wr),
    .mem_we_o        (mem_we),
    .bypass_o        (bypass),
    .full_o          (wbuf_full_o),
    .empty_o         (wbuf_empty_o)
  );

  data_mem u_mem (
    .clk_i     (clk_i),
    .wr_i      (mem_wr),
    .we_i      (mem_we),
    .rd_addr_i (load_addr_i),
    .rd_set_i  (load_set_i),
    .re_i      (load_v_i),
    .rd_data_o (rd_data)
  );

  load_merge u_merge (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .load_v_i    (load_v_i),
    .mem_data_i  (rd_data),
    .bypass_i    (bypass),
    .load_data_o (load_data_o),
    .load_v_o    (load_v_o)
  );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int RESET_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;   // 4 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* testbench/tb_dcache_store_path.sv */
`timescale 1ns/100ps

module tb_dcache_store_path
  import cache_pkg::*;
  import wbuf_pkg::*;
();

  localparam int TIMEOUT = 50;
  localparam int PAT_WORDS = 512;
  localparam int REC_W = 5;   // cmd addr data mask set

  logic        clk;
  logic        rst_n;
  wbuf_entry_t store;
  logic        store_v;
  addr_t       load_addr;
  logic        load_set;
  logic        load_v;
  word_t       load_data;
  logic        load_v_out;
  logic        wbuf_full;
  logic        wbuf_empty;

  logic [31:0] pat [PAT_WORDS];
  word_t       shadow_mem [NUM_WAYS][2**INDEX_W];
  wbuf_entry_t model_q [$];   // oldest entry at the front
  logic        pending;
  word_t       pending_exp;
  string       pending_name;

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  dcache_store_path DUT (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .store_i      (store),
    .store_v_i    (store_v),
    .load_addr_i  (load_addr),
    .load_set_i   (load_set),
    .load_v_i     (load_v),
    .load_data_o  (load_data),
    .load_v_o     (load_v_out),
    .wbuf_full_o  (wbuf_full),
    .wbuf_empty_o (wbuf_empty)
  );

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
    end
  endtask

  function automatic word_t merge_bytes(input word_t base, input word_t data, input mask_t mask);
    word_t w;
    w = base;
    for (int b = 0; b < MASK_W; b++) begin
      if (mask[b]) w[b*BYTE_W +: BYTE_W] = data[b*BYTE_W +: BYTE_W];
    end
    return w;
  endfunction

  function automatic logic same_word(input addr_t a, input addr_t b);
    return a[ADDR_W-1:INDEX_LSB] == b[ADDR_W-1:INDEX_LSB];
  endfunction

  // memory word, then buffered stores oldest first, then the store of this cycle
  function automatic word_t model_load(input addr_t addr, input logic set, input logic st_v,
                                       input wbuf_entry_t st);
    word_t w;
    w = shadow_mem[set][addr[INDEX_LSB +: INDEX_W]];
    foreach (model_q[i]) begin
      if (same_word(model_q[i].addr, addr)) w = merge_bytes(w, model_q[i].data, model_q[i].mask);
    end
    if (st_v && same_word(st.addr, addr)) w = merge_bytes(w, st.data, st.mask);
    return w;
  endfunction

  task automatic model_step(input logic st_v, input wbuf_entry_t st, input logic ld_v,
                            input string name);
    wbuf_entry_t head;
    index_t      idx;
    if (st_v) begin
      if (model_q.size() == WBUF_ELS && ld_v) begin
        abort_run({name, ": pattern stores into a full buffer while a load blocks draining"});
      end
      model_q.push_back(st);
    end
    if (!ld_v && model_q.size() != 0) begin   // memory free, oldest entry drains
      head = model_q.pop_front();
      idx = head.addr[INDEX_LSB +: INDEX_W];
      shadow_mem[head.set][idx] = merge_bytes(shadow_mem[head.set][idx], head.data, head.mask);
    end
  endtask

  task automatic run_cycle(input logic st_v, input wbuf_entry_t st, input logic ld_v,
                           input addr_t ld_addr, input logic ld_set, input word_t ld_exp,
                           input string name);
    word_t model_exp;
    @(posedge clk);
    store_v   <= st_v;
    store     <= st;
    load_v    <= ld_v;
    load_addr <= ld_addr;
    load_set  <= ld_set;
    @(negedge clk);
    check_value({name, " full flag"}, 32'(model_q.size() == WBUF_ELS), 32'(wbuf_full));
    check_value({name, " empty flag"}, 32'(model_q.size() == 0), 32'(wbuf_empty));
    if (pending) begin   // result of the load issued one cycle earlier
      check_value({pending_name, " load valid"}, 32'd1, 32'(load_v_out));
      check_value({pending_name, " load word"}, pending_exp, load_data);
    end else begin
      check_value({name, " load valid"}, 32'd0, 32'(load_v_out));
    end
    pending = ld_v;
    if (ld_v) begin
      model_exp = model_load(ld_addr, ld_set, st_v, st);
      check_value({name, " pattern vs model"}, model_exp, ld_exp);
      pending_exp = ld_exp;
      pending_name = name;
    end
    model_step(st_v, st, ld_v, name);
  endtask

  task automatic wait_empty(input string name);
    int n;
    n = 0;
    while (wbuf_empty !== 1'b1) begin
      if (n == TIMEOUT) abort_run({name, ": write buffer did not drain"});
      run_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0, name);
      n++;
    end
  endtask

  initial begin
    int          r;
    int          n;
    logic [31:0] cmd;
    wbuf_entry_t entry;
    wbuf_entry_t held;
    logic        held_v;
    string       name;
    store_v   <= 1'b0;
    store     <= '0;
    load_v    <= 1'b0;
    load_addr <= '0;
    load_set  <= 1'b0;
    pending = 1'b0;
    held_v = 1'b0;
    held = '0;
    for (int i = 0; i < PAT_WORDS; i++) pat[i] = '0;   // cmd 0 ends the list
    for (int w = 0; w < NUM_WAYS; w++) begin
      for (int i = 0; i < 2**INDEX_W; i++) shadow_mem[w][i] = '0;
    end
    $readmemh("testbench/store_path_patterns.txt", pat);

    n = 0;
    while (rst_n !== 1'b1) begin
      if (n == TIMEOUT) abort_run("reset was never released");
      @(posedge clk);
      n++;
    end
    @(negedge clk);
    check_value("after reset empty", 32'd1, 32'(wbuf_empty));
    check_value("after reset full", 32'd0, 32'(wbuf_full));

    r = 0;
    while (r < PAT_WORDS / REC_W && pat[r*REC_W] != 0) begin
      cmd = pat[r*REC_W];
      entry.addr = pat[r*REC_W+1];
      entry.data = pat[r*REC_W+2];
      entry.mask = pat[r*REC_W+3][MASK_W-1:0];
      entry.set  = pat[r*REC_W+4][0];
      name = $sformatf("record %0d", r);
      if (held_v && cmd != 2) abort_run({name, ": store-with-load record not followed by a load"});
      case (cmd)
        1: run_cycle(1'b1, entry, 1'b0, '0, 1'b0, '0, name);
        2: begin
          run_cycle(held_v, held, 1'b1, entry.addr, entry.set, entry.data, name);
          held_v = 1'b0;
        end
        3: begin
          for (n = 0; n < int'(entry.addr); n++) begin
            run_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0, name);
          end
        end
        4: begin   // store shares the cycle of the next load
          held = entry;
          held_v = 1'b1;
        end
        5: wait_empty(name);
        default: abort_run({name, ": unknown pattern command"});
      endcase
      r++;
    end
    if (held_v) abort_run("pattern list ends with a store waiting for a load");
    run_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0, "final flush");

    $display("Finished with no errors");
    $finish;
  end

endmodule

/* testbench/store_path_patterns.txt */
// columns: cmd addr data mask set, one record per line
// cmd 1 store, 2 load (data is the expected word), 3 idle (addr is cycles),
// cmd 4 store in the same cycle as the next load, 5 idle until buffer empty
// store then drain, load back
00000001 00000100 11223344 0000000f 00000000
00000005 00000000 00000000 00000000 00000000
00000002 00000100 11223344 00000000 00000000
// two ways at one index
00000001 00000200 aaaa0001 0000000f 00000000
00000001 00000600 bbbb0002 0000000f 00000001
00000003 00000002 00000000 00000000 00000000
00000002 00000200 aaaa0001 00000000 00000000
00000002 00000600 bbbb0002 00000000 00000001
// partial store held in the buffer by loads
00000001 00000300 01020304 0000000f 00000000
00000005 00000000 00000000 00000000 00000000
00000004 00000300 aabbccdd 00000003 00000000
00000002 00000100 11223344 00000000 00000000
00000002 00000300 0102ccdd 00000000 00000000
00000005 00000000 00000000 00000000 00000000
00000002 00000300 0102ccdd 00000000 00000000
// youngest wins, two buffered entries
00000001 00000400 10203040 0000000f 00000001
00000005 00000000 00000000 00000000 00000000
00000004 00000400 a1a2a3a4 00000003 00000001
00000002 00000100 11223344 00000000 00000000
00000004 00000400 b1b2b3b4 00000006 00000001
00000002 00000200 aaaa0001 00000000 00000000
00000002 00000400 10b2b3a4 00000000 00000001
00000005 00000000 00000000 00000000 00000000
00000002 00000400 10b2b3a4 00000000 00000001
// youngest wins, buffered entry and same cycle store
00000004 00000400 c1c2c3c4 00000005 00000001
00000002 00000100 11223344 00000000 00000000
00000004 00000400 d1d2d3d4 00000003 00000001
00000002 00000400 10c2d3d4 00000000 00000001
00000005 00000000 00000000 00000000 00000000
00000002 00000400 10c2d3d4 00000000 00000001
// back to back loads fill the buffer
00000004 00000500 55555555 0000000f 00000000
00000002 00000100 11223344 00000000 00000000
00000002 00000100 11223344 00000000 00000000
00000004 00000504 66666666 0000000f 00000000
00000002 00000200 aaaa0001 00000000 00000000
00000002 00000300 0102ccdd 00000000 00000000
00000001 00000508 77777777 0000000f 00000000
00000005 00000000 00000000 00000000 00000000
00000002 00000500 55555555 00000000 00000000
00000002 00000504 66666666 00000000 00000000
00000002 00000508 77777777 00000000 00000000
00000002 00000400 10c2d3d4 00000000 00000001
00000002 00000600 bbbb0002 00000000 00000001
00000003 00000003 00000000 00000000 00000000

/* sources.f */
verilog/cache_pkg.sv
verilog/wbuf_pkg.sv
verilog/write_buffer_queue.sv
verilog/write_buffer.sv
verilog/data_mem.sv
verilog/load_merge.sv
verilog/dcache_store_path.sv
testbench/tb_clock_gen.sv
testbench/tb_dcache_store_path.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_dcache_store_path
LINT_TOP  ?= dcache_store_path
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
